/* async_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module async_fifo
(
    input  wire                  clk_wt,
    input  wire                  rst_n_wt,
    input  wire                  clk_rd,
    input  wire                  rst_n_rd,

    input  wire                  wr_en,
    input  stream_pkg::payload_t wr_data,
    output logic                 full,

    input  wire                  rd_en,
    output logic                 empty,
    output stream_pkg::payload_t rd_data,

    output logic                 ram_wen,
    output fifo_pkg::ram_addr_t  ram_waddr,
    output stream_pkg::payload_t ram_din,
    output logic                 ram_ren,
    output fifo_pkg::ram_addr_t  ram_raddr,
    input  stream_pkg::payload_t ram_dout
);

    localparam int ptr_w = $bits(fifo_pkg::fifo_ptr_t);
    localparam fifo_pkg::fifo_ptr_t ptr_one = 1;

    function automatic fifo_pkg::fifo_ptr_t bin2gray(input fifo_pkg::fifo_ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    // write side
    fifo_pkg::fifo_ptr_t wptr_bin;
    fifo_pkg::fifo_ptr_t wptr_add1_bin;
    fifo_pkg::fifo_ptr_t wptr_gray;          // registered copy sent to read side
    fifo_pkg::fifo_ptr_t rptr_gray_w_p2;     // first sync stage
    fifo_pkg::fifo_ptr_t rptr_gray_w_p1;     // read pointer seen by write side
    fifo_pkg::fifo_ptr_t wptr_next_gray;
    logic                wr_ok;

    // read side
    fifo_pkg::fifo_ptr_t rptr_bin;
    fifo_pkg::fifo_ptr_t rptr_add1_bin;
    fifo_pkg::fifo_ptr_t rptr_gray;
    fifo_pkg::fifo_ptr_t wptr_gray_r_p2;
    fifo_pkg::fifo_ptr_t wptr_gray_r_p1;     // write pointer seen by read side
    fifo_pkg::fifo_ptr_t rptr_next_gray;
    logic                rd_ok;

    assign wr_ok     = wr_en & ~full;
    assign ram_wen   = wr_ok;
    assign ram_waddr = wptr_bin[ptr_w-2:0];
    assign ram_din   = wr_data;

    assign rd_ok     = rd_en & ~empty;
    assign ram_ren   = rd_ok;
    assign ram_raddr = rptr_bin[ptr_w-2:0];
    assign rd_data   = ram_dout;

    // pointer value after this cycle, in gray form
    assign wptr_next_gray = wr_ok ? bin2gray(wptr_add1_bin) : bin2gray(wptr_bin);
    assign rptr_next_gray = rd_ok ? bin2gray(rptr_add1_bin) : bin2gray(rptr_bin);

    always_ff @(posedge clk_wt or negedge rst_n_wt)
    begin
        if (!rst_n_wt)
        begin
            wptr_bin      <= '0;
            wptr_add1_bin <= ptr_one;
        end
        else if (wr_ok)
        begin
            wptr_bin      <= wptr_bin + ptr_one;
            wptr_add1_bin <= wptr_add1_bin + ptr_one;
        end
    end

    always_ff @(posedge clk_wt or negedge rst_n_wt)
    begin
        if (!rst_n_wt)
        begin
            wptr_gray      <= '0;
            rptr_gray_w_p2 <= '0;
            rptr_gray_w_p1 <= '0;
            full           <= 1'b0;
        end
        else
        begin
            wptr_gray      <= bin2gray(wptr_bin);
            rptr_gray_w_p2 <= rptr_gray;     // crosses from clk_rd
            rptr_gray_w_p1 <= rptr_gray_w_p2;
            // full when write leads read by one lap, gray top two bits differ
            full <= wptr_next_gray ==
                {~rptr_gray_w_p1[ptr_w-1 -: 2], rptr_gray_w_p1[ptr_w-3:0]};
        end
    end

    always_ff @(posedge clk_rd or negedge rst_n_rd)
    begin
        if (!rst_n_rd)
        begin
            rptr_bin      <= '0;
            rptr_add1_bin <= ptr_one;
        end
        else if (rd_ok)
        begin
            rptr_bin      <= rptr_bin + ptr_one;
            rptr_add1_bin <= rptr_add1_bin + ptr_one;
        end
    end

    always_ff @(posedge clk_rd or negedge rst_n_rd)
    begin
        if (!rst_n_rd)
        begin
            rptr_gray      <= '0;
            wptr_gray_r_p2 <= '0;
            wptr_gray_r_p1 <= '0;
            empty          <= 1'b1;
        end
        else
        begin
            rptr_gray      <= bin2gray(rptr_bin);
            wptr_gray_r_p2 <= wptr_gray;     // crosses from clk_wt
            wptr_gray_r_p1 <= wptr_gray_r_p2;
            empty          <= rptr_next_gray == wptr_gray_r_p1;  // stale write ptr, pessimistic
        end
    end

endmodule

`default_nettype wire

/* bridge_defines.svh */
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// number of lane FIFOs, must match the width of the lane field
`define BRIDGE_LANES 4

// entries per lane FIFO, power of two
`define BRIDGE_FIFO_DEPTH 16

// payload bits per beat
`define BRIDGE_DATA_WIDTH 32

// beats the drain may have outstanding downstream
`define BRIDGE_CREDITS 4

`endif

/* credit_drain.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_defines.svh"

module credit_drain
(
    input  wire                      clk_rd,
    input  wire                      rst_n_rd,
    input  wire [`BRIDGE_LANES-1:0]  empty,
    input  stream_pkg::payload_t     rd_data [`BRIDGE_LANES],
    input  wire                      credit_return,
    output logic [`BRIDGE_LANES-1:0] rd_en,
    output logic                     out_valid,
    output stream_pkg::beat_t        out_beat
);

    stream_pkg::lane_id_t    last_lane;   // lane served most recently
    stream_pkg::lane_id_t    pick_lane;
    stream_pkg::lane_id_t    sel_lane_q;  // lane whose RAM word arrives this cycle
    stream_pkg::credit_cnt_t credits;
    logic                    any_ready;
    logic                    issue;

    assign any_ready = |(~empty);
    assign issue     = any_ready && (credits != '0);

    // first non-empty lane after the last one served
    always_comb
    begin : rr_pick
        int idx;
        pick_lane = last_lane;
        for (int off = `BRIDGE_LANES; off >= 1; off--)
        begin
            idx = (int'(last_lane) + off) % `BRIDGE_LANES;
            if (!empty[idx])
                pick_lane = stream_pkg::lane_id_t'(idx);  // lowest offset wins
        end
    end

    always_comb
    begin
        rd_en = '0;
        if (issue)
            rd_en[pick_lane] = 1'b1;
    end

    always_ff @(posedge clk_rd or negedge rst_n_rd)
    begin
        if (!rst_n_rd)
        begin
            last_lane  <= stream_pkg::lane_id_t'(`BRIDGE_LANES - 1);  // lane 0 goes first
            sel_lane_q <= '0;
            out_valid  <= 1'b0;
        end
        else
        begin
            out_valid <= issue;
            if (issue)
            begin
                last_lane  <= pick_lane;
                sel_lane_q <= pick_lane;
            end
        end
    end

    // RAM word lands one cycle after rd_en, lane rebuilt from the FIFO index
    assign out_beat.lane    = sel_lane_q;
    assign out_beat.payload = rd_data[sel_lane_q];

    // spend on issue, regain on credit_return, both may coincide
    always_ff @(posedge clk_rd or negedge rst_n_rd)
    begin
        if (!rst_n_rd)
            credits <= stream_pkg::credit_cnt_t'(`BRIDGE_CREDITS);
        else
        begin
            case ({issue, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* fifo_pkg.sv */
`default_nettype none

`include "bridge_defines.svh"

package fifo_pkg;

    // word address into one lane RAM
    typedef logic [$clog2(`BRIDGE_FIFO_DEPTH)-1:0] ram_addr_t;

    // address plus wrap bit, binary or gray coded
    typedef logic [$clog2(`BRIDGE_FIFO_DEPTH):0] fifo_ptr_t;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+.
stream_pkg.sv
fifo_pkg.sv
lane_ram.sv
async_fifo.sv
lane_distributor.sv
credit_drain.sv
lane_bridge_top.sv
tb_clock_gen.sv
lane_bridge_tb.sv

/* lane_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_defines.svh"

module lane_bridge_tb;

    localparam int lanes        = `BRIDGE_LANES;
    localparam int depth        = `BRIDGE_FIFO_DEPTH;
    localparam int credit_max   = `BRIDGE_CREDITS;
    localparam int random_beats = 200;
    localparam int rr_per_lane  = 8;
    localparam int total_beats  = random_beats + depth + credit_max + lanes * rr_per_lane;
    localparam int watchdog_cycles = total_beats * 40 + 2000;

    wire               clk_wt;
    wire               clk_rd;
    logic              rst_n_wt;
    logic              rst_n_rd;
    logic              in_valid;
    stream_pkg::beat_t in_beat;
    logic              in_ready;
    logic              credit_return = 1'b0;
    logic              out_valid;
    stream_pkg::beat_t out_beat;

    stream_pkg::payload_t sb [lanes][$];    // expected payloads per lane
    int                   ret_due [$];      // read cycle at which each credit goes back
    int                   rd_cycle      = 0;
    int                   credit_delay  = 0;
    bit                   credit_jitter = 1'b0;
    bit                   hold_credits  = 1'b0;
    int                   outstanding   = 0;
    int                   out_count     = 0;
    bit                   rr_check      = 1'b0;
    bit                   rr_have_last  = 1'b0;
    stream_pkg::lane_id_t rr_last;

    tb_clock_gen #(.phase_ns(0.0)) u_clk_rd (.clk(clk_rd));
    tb_clock_gen #(.phase_ns(3.0)) u_clk_wt (.clk(clk_wt));

    lane_bridge_top UUT
    (
        .clk_wt        (clk_wt),
        .rst_n_wt      (rst_n_wt),
        .clk_rd        (clk_rd),
        .rst_n_rd      (rst_n_rd),
        .in_valid      (in_valid),
        .in_beat       (in_beat),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_beat      (out_beat)
    );

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string test, input longint expected,
                                   input longint actual);
        $display("FAIL %s: expected %0h, actual %0h", test, expected, actual);
        stop_with_failure();
    endtask

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int l = 0; l < lanes; l++)
            n += sb[l].size();
        return n;
    endfunction

    function automatic bit all_lanes_loaded();
        for (int l = 0; l < lanes; l++)
        begin
            if (sb[l].size() == 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // called 1 ns after a clk_wt edge, returns at the same phase
    task automatic send_beat(input stream_pkg::lane_id_t lane, input stream_pkg::payload_t data);
        bit taken;
        taken           = 1'b0;
        in_valid        = 1'b1;
        in_beat.lane    = lane;
        in_beat.payload = data;
        while (!taken)
        begin
            @(negedge clk_wt);
            taken = in_ready;    // full only moves on clk_wt edges
            @(posedge clk_wt);
            #1;
        end
        sb[lane].push_back(data);
        in_valid = 1'b0;
    endtask

    // returns once every queue is empty, or after a long gap with no output
    task automatic wait_drained(input string test);
        int idle;
        int seen;
        idle = 0;
        seen = out_count;
        while ((pending_beats() != 0 || ret_due.size() != 0) && idle < 500)
        begin
            @(negedge clk_rd);
            if (out_count != seen)
            begin
                seen = out_count;
                idle = 0;
            end
            else
                idle++;
        end
        assert (pending_beats() == 0) else report_mismatch(test, 0, pending_beats());
    endtask

    // downstream receiver, hands back one credit per consumed beat
    always @(posedge clk_rd)
    begin
        rd_cycle = rd_cycle + 1;
        if (out_valid)
            ret_due.push_back(rd_cycle + credit_delay + (credit_jitter ? $urandom_range(0, 4) : 0));
        #1;
        if (!hold_credits && ret_due.size() != 0 && ret_due[0] <= rd_cycle)
        begin
            void'(ret_due.pop_front());
            credit_return = 1'b1;
        end
        else
            credit_return = 1'b0;
    end

    always @(posedge clk_rd)
    begin
        if (rst_n_rd)
        begin
            assert (!(outstanding == credit_max && out_valid))
                else report_mismatch("credit_stall", 0, out_valid);
            outstanding = outstanding + int'(out_valid) - int'(credit_return);
        end
    end

    always @(posedge clk_rd)
    begin : check_output
        stream_pkg::lane_id_t lane;
        stream_pkg::payload_t head;
        bit                   loaded;
        if (rst_n_rd && out_valid)
        begin
            out_count = out_count + 1;
            lane      = out_beat.lane;
            if (sb[lane].size() == 0)
            begin
                $display("FAIL scoreboard: beat on lane %0d with no beat expected", lane);
                stop_with_failure();
            end
            else
            begin
                loaded = all_lanes_loaded();    // every lane still had data at issue
                head   = sb[lane].pop_front();
                if (rr_check && loaded && rr_have_last)
                    assert (lane == stream_pkg::lane_id_t'(rr_last + 1'b1))
                        else report_mismatch("round_robin", 
                                             stream_pkg::lane_id_t'(rr_last + 1'b1), lane);
                rr_last      = lane;
                rr_have_last = rr_check;
                assert (out_beat.payload == head)
                    else report_mismatch("data_order", head, out_beat.payload);
            end
        end
    end

    initial
    begin : main
        int                   accepted;
        int                   stall;
        int                   drained_before;
        int                   drained;
        bit                   taken;
        stream_pkg::payload_t data;

        void'($urandom(79));
        rst_n_wt = 1'b0;
        rst_n_rd = 1'b0;
        in_valid = 1'b0;
        in_beat  = '0;
        fork
            begin
                repeat (8) @(posedge clk_wt);
                #1 rst_n_wt = 1'b1;
            end
            begin
                repeat (8) @(posedge clk_rd);
                #1 rst_n_rd = 1'b1;
            end
        join

        @(negedge clk_wt);
        assert (in_ready == 1'b1) else report_mismatch("reset_ready", 1, in_ready);
        assert (out_valid == 1'b0) else report_mismatch("reset_valid", 0, out_valid);

        // random lanes and gaps, credits come back late and uneven
        credit_delay  = 2;
        credit_jitter = 1'b1;
        @(posedge clk_wt);
        #1;
        for (int n = 0; n < random_beats; n++)
        begin
            send_beat(stream_pkg::lane_id_t'($urandom_range(0, lanes - 1)), $urandom);
            if ($urandom_range(0, 3) == 0)
            begin
                @(posedge clk_wt);
                #1;
            end
        end
        wait_drained("random_traffic");

        // credits withheld, lane 1 written until it stalls
        credit_delay   = 0;
        credit_jitter  = 1'b0;
        hold_credits   = 1'b1;
        @(posedge clk_wt);
        #1;
        drained_before = out_count;
        accepted       = 0;
        stall          = 0;
        in_valid       = 1'b1;
        in_beat.lane   = 1;
        while (stall < 20)
        begin
            data            = $urandom;
            in_beat.payload = data;
            @(negedge clk_wt);
            taken = in_ready;
            @(posedge clk_wt);
            #1;
            if (taken)
            begin
                sb[1].push_back(data);
                accepted++;
                stall = 0;
            end
            else
                stall++;
        end
        in_valid = 1'b0;
        drained  = out_count - drained_before;
        assert (drained == credit_max)
            else report_mismatch("backpressure_drain", credit_max, drained);
        assert (accepted == depth + drained)
            else report_mismatch("backpressure_fill", depth + drained, accepted);
        repeat (4)
        begin
            @(negedge clk_wt);
            assert (in_ready == 1'b0) else report_mismatch("full_lane_ready", 0, in_ready);
        end
        @(posedge clk_wt);
        #1 in_beat.lane = 2;
        @(negedge clk_wt);
        assert (in_ready == 1'b1) else report_mismatch("empty_lane_ready", 1, in_ready);
        hold_credits = 1'b0;
        wait_drained("backpressure");

        // load all four lanes, then release credits with no delay
        hold_credits   = 1'b1;
        drained_before = out_count;
        @(posedge clk_wt);
        #1;
        for (int k = 0; k < rr_per_lane; k++)
        begin
            for (int l = 0; l < lanes; l++)
                send_beat(stream_pkg::lane_id_t'(l), $urandom);
        end
        while (out_count - drained_before < credit_max)
            @(negedge clk_rd);
        repeat (8) @(negedge clk_rd);    // last write pointers cross over
        rr_have_last = 1'b0;
        rr_check     = 1'b1;
        hold_credits = 1'b0;
        wait_drained("round_robin");
        rr_check = 1'b0;

        $display("All tests passed");
        $finish;
    end

    initial
    begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_rd);
        $display("watchdog expired after %0d read clock cycles, the run is hung",
                 watchdog_cycles);
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* lane_bridge_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_defines.svh"

module lane_bridge_top
(
    input  wire               clk_wt,
    input  wire               rst_n_wt,
    input  wire               clk_rd,
    input  wire               rst_n_rd,
    input  wire               in_valid,
    input  stream_pkg::beat_t in_beat,
    output logic              in_ready,
    input  wire               credit_return,
    output logic              out_valid,
    output stream_pkg::beat_t out_beat
);

    logic [`BRIDGE_LANES-1:0] lane_wr_en;
    logic [`BRIDGE_LANES-1:0] lane_full;
    stream_pkg::payload_t     lane_wr_data;    // shared by all lanes
    logic [`BRIDGE_LANES-1:0] lane_rd_en;
    logic [`BRIDGE_LANES-1:0] lane_empty;
    stream_pkg::payload_t     lane_rd_data [`BRIDGE_LANES];

    lane_distributor u_distributor
    (
        .in_valid (in_valid),
        .in_beat  (in_beat),
        .full     (lane_full),
        .in_ready (in_ready),
        .wr_en    (lane_wr_en),
        .wr_data  (lane_wr_data)
    );

    for (genvar i = 0; i < `BRIDGE_LANES; i++)
    begin : g_lane
        logic                 ram_wen;
        fifo_pkg::ram_addr_t  ram_waddr;
        stream_pkg::payload_t ram_din;
        logic                 ram_ren;
        fifo_pkg::ram_addr_t  ram_raddr;
        stream_pkg::payload_t ram_dout;

        async_fifo u_fifo
        (
            .clk_wt    (clk_wt),
            .rst_n_wt  (rst_n_wt),
            .clk_rd    (clk_rd),
            .rst_n_rd  (rst_n_rd),
            .wr_en     (lane_wr_en[i]),
            .wr_data   (lane_wr_data),
            .full      (lane_full[i]),
            .rd_en     (lane_rd_en[i]),
            .empty     (lane_empty[i]),
            .rd_data   (lane_rd_data[i]),
            .ram_wen   (ram_wen),
            .ram_waddr (ram_waddr),
            .ram_din   (ram_din),
            .ram_ren   (ram_ren),
            .ram_raddr (ram_raddr),
            .ram_dout  (ram_dout)
        );

        lane_ram u_ram
        (
            .clk_wt (clk_wt),
            .clk_rd (clk_rd),
            .wen    (ram_wen),
            .waddr  (ram_waddr),
            .din    (ram_din),
            .ren    (ram_ren),
            .raddr  (ram_raddr),
            .dout   (ram_dout)
        );
    end

    credit_drain u_drain
    (
        .clk_rd        (clk_rd),
        .rst_n_rd      (rst_n_rd),
        .empty         (lane_empty),
        .rd_data       (lane_rd_data),
        .credit_return (credit_return),
        .rd_en         (lane_rd_en),
        .out_valid     (out_valid),
        .out_beat      (out_beat)
    );

endmodule

`default_nettype wire

/* lane_distributor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_defines.svh"

module lane_distributor
(
    input  wire                     in_valid,
    input  stream_pkg::beat_t       in_beat,
    input  wire [`BRIDGE_LANES-1:0] full,
    output logic                    in_ready,
    output logic [`BRIDGE_LANES-1:0] wr_en,
    output stream_pkg::payload_t    wr_data
);

    logic accept;

    // ready follows only the lane the beat is aimed at
    assign in_ready = ~full[in_beat.lane];
    assign accept   = in_valid & in_ready;

    // lane is implied by the FIFO that stores the beat
    assign wr_data = in_beat.payload;

    always_comb
    begin
        wr_en = '0;
        for (int i = 0; i < `BRIDGE_LANES; i++)
        begin
            if (accept && (int'(in_beat.lane) == i))
                wr_en[i] = 1'b1;   // one-hot decode of the lane field
        end
    end

endmodule

`default_nettype wire

/* lane_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bridge_defines.svh"

module lane_ram
(
    input  wire                  clk_wt,
    input  wire                  clk_rd,
    input  wire                  wen,
    input  fifo_pkg::ram_addr_t  waddr,
    input  stream_pkg::payload_t din,
    input  wire                  ren,
    input  fifo_pkg::ram_addr_t  raddr,
    output stream_pkg::payload_t dout
);

    stream_pkg::payload_t mem [`BRIDGE_FIFO_DEPTH];

    always_ff @(posedge clk_wt)
    begin
        if (wen)
            mem[waddr] <= din;
    end

    // registered read, holds its value between reads
    always_ff @(posedge clk_rd)
    begin
        if (ren)
            dout <= mem[raddr];
    end

endmodule

`default_nettype wire

/* stream_pkg.sv */
`default_nettype none

`include "bridge_defines.svh"

package stream_pkg;

    // payload of one beat
    typedef logic [`BRIDGE_DATA_WIDTH-1:0] payload_t;

    // lane number carried with each beat
    typedef logic [$clog2(`BRIDGE_LANES)-1:0] lane_id_t;

    // tagged beat, lane in the upper bits
    typedef struct packed
    {
        lane_id_t lane;
        payload_t payload;
    } beat_t;

    // credit count, 0 up to the credit limit inclusive
    typedef logic [$clog2(`BRIDGE_CREDITS+1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
#(
    parameter real phase_ns  = 0.0,
    parameter real period_ns = 10.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        #(period_ns / 2.0 + phase_ns);    // first rising edge lands here
        forever
        begin
            clk = 1'b1;
            #(period_ns / 2.0);
            clk = 1'b0;
            #(period_ns / 2.0);
        end
    end

endmodule

`default_nettype wire
